//--- hw/cpu_pkg.sv
// Shared widths, opcodes, control word and AXI4-Lite payload types; imported by every core block.
package cpu_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [15:0] addr_t;  // Byte address.
    typedef logic [7:0]  byte_t;  // Data byte.
    typedef logic [31:0] word_t;  // AXI data word.
    typedef logic [2:0]  step_t;  // Step within an instruction, 0 to 4.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction set
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam byte_t OP_NOP      = 8'h00;
    localparam byte_t OP_LDI      = 8'h01;
    localparam byte_t OP_LDA      = 8'h02;
    localparam byte_t OP_STA      = 8'h03;
    localparam byte_t OP_ADD      = 8'h04;
    localparam byte_t OP_SUB      = 8'h05;
    localparam byte_t OP_JMP      = 8'h06;
    localparam byte_t OP_JNZ      = 8'h07;
    localparam byte_t OP_HALT_MIN = 8'h08;  // Anything from here up stops the core.

    localparam addr_t RESET_PC = 16'h0000;

    typedef enum logic [1:0] {
        ALU_PASS = 2'd0,
        ALU_ADD  = 2'd1,
        ALU_SUB  = 2'd2
    } alu_op_e;

    typedef enum logic {
        SEL_PC   = 1'b0,
        SEL_OPND = 1'b1
    } addr_sel_e;

    // One decoded step.
    typedef struct packed {
        logic      bus_rd;
        logic      bus_wr;
        addr_sel_e addr_sel;
        logic      load_opnd_lo;
        logic      load_opnd_hi;
        logic      load_a;
        alu_op_e   alu_op;
        logic      pc_inc;
        logic      pc_load;
        logic      pc_cond;    // Jump only when A is not zero.
        logic      last_step;
        logic      halt;
    } ctrl_word_t;

    typedef struct packed {
        addr_t addr;
        byte_t wdata;
        logic  write;
    } bus_req_t;

    typedef enum logic [1:0] {
        ISSUE,
        WAIT_BUS,
        HALTED
    } seq_state_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // AXI4-Lite payloads
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        addr_t      addr;
        logic [2:0] prot;
    } axil_aw_t;

    typedef struct packed {
        word_t      data;
        logic [3:0] strb;
    } axil_w_t;

    typedef struct packed {
        addr_t      addr;
        logic [2:0] prot;
    } axil_ar_t;

    typedef struct packed {
        word_t      data;
        logic [1:0] resp;
    } axil_r_t;

endpackage

//--- hw/opcode_decoder.sv
// Combinational instruction decoder; maps the current opcode and step onto the core control word.
`timescale 1ns/10ps

module opcode_decoder (
    input  cpu_pkg::byte_t      opcode,
    input  cpu_pkg::step_t      step,
    output cpu_pkg::ctrl_word_t ctrl
);
    import cpu_pkg::*;

    logic       is_fetch;
    logic       is_halt;
    logic [3:0] grp;        // One-hot on opcode[2:1].
    logic       opnd_step;

    ctrl_word_t fetch_w;
    ctrl_word_t opnd_w;
    ctrl_word_t g_nop_ldi;
    ctrl_word_t g_lda_sta;
    ctrl_word_t g_add_sub;
    ctrl_word_t g_jmp_jnz;
    ctrl_word_t halt_w;

    assign is_fetch = (step == 3'd0);
    assign is_halt  = !is_fetch && (opcode >= OP_HALT_MIN);

    always_comb begin
        grp = 4'b0000;
        if (!is_fetch && !is_halt) begin
            grp[opcode[2:1]] = 1'b1;
        end
    end

    // Absolute-address groups share the two operand byte fetches.
    assign opnd_step = (grp[3:1] != 3'b000) && ((step == 3'd1) || (step == 3'd2));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Shared steps
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        fetch_w        = '0;
        fetch_w.bus_rd = is_fetch;  // Opcode read at pc.
        fetch_w.pc_inc = is_fetch;
    end

    always_comb begin
        opnd_w              = '0;
        opnd_w.bus_rd       = opnd_step;
        opnd_w.pc_inc       = opnd_step;
        opnd_w.load_opnd_lo = opnd_step && (step == 3'd1);  // Low byte first.
        opnd_w.load_opnd_hi = opnd_step && (step == 3'd2);
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Per-group execute steps
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        g_nop_ldi = '0;
        if (grp[0] && (step == 3'd1)) begin
            g_nop_ldi.last_step = 1'b1;
            if (opcode[0]) begin  // LDI takes its byte from the stream.
                g_nop_ldi.bus_rd = 1'b1;
                g_nop_ldi.pc_inc = 1'b1;
                g_nop_ldi.load_a = 1'b1;
                g_nop_ldi.alu_op = ALU_PASS;
            end
        end
    end

    always_comb begin
        g_lda_sta = '0;
        if (grp[1] && (step == 3'd3)) begin
            g_lda_sta.addr_sel  = SEL_OPND;
            g_lda_sta.last_step = 1'b1;
            g_lda_sta.bus_wr    = opcode[0];
            g_lda_sta.bus_rd    = !opcode[0];
            g_lda_sta.load_a    = !opcode[0];
            g_lda_sta.alu_op    = ALU_PASS;
        end
    end

    always_comb begin
        g_add_sub = '0;
        if (grp[2] && (step == 3'd3)) begin
            g_add_sub.bus_rd    = 1'b1;
            g_add_sub.addr_sel  = SEL_OPND;
            g_add_sub.load_a    = 1'b1;
            g_add_sub.alu_op    = opcode[0] ? ALU_SUB : ALU_ADD;
            g_add_sub.last_step = 1'b1;
        end
    end

    always_comb begin
        g_jmp_jnz = '0;
        if (grp[3] && (step == 3'd3)) begin
            g_jmp_jnz.pc_load   = 1'b1;
            g_jmp_jnz.pc_cond   = opcode[0];  // JNZ.
            g_jmp_jnz.last_step = 1'b1;
        end
    end

    always_comb begin
        halt_w      = '0;
        halt_w.halt = is_halt;
    end

    assign ctrl = fetch_w | opnd_w | g_nop_ldi | g_lda_sta | g_add_sub | g_jmp_jnz | halt_w;

    // A step makes at most one bus access.
    always_comb begin
        assert (!(ctrl.bus_rd && ctrl.bus_wr))
            else $error("decoder drives read and write in one step");
    end

endmodule

//--- hw/step_sequencer.sv
// Step sequencer FSM; holds the instruction register, paces steps against the bus and stops on halt.
`timescale 1ns/10ps

module step_sequencer (
    input  logic                clk,
    input  logic                rst_n,
    input  cpu_pkg::ctrl_word_t ctrl,
    input  logic                bus_done,
    input  cpu_pkg::byte_t      rdata_byte,
    output cpu_pkg::byte_t      opcode,
    output cpu_pkg::step_t      step,
    output logic                req_valid,
    output logic                advance,
    output logic                halted
);
    import cpu_pkg::*;

    seq_state_e state;
    logic       needs_bus;
    step_t      next_step;

    assign needs_bus = ctrl.bus_rd | ctrl.bus_wr;
    assign next_step = ctrl.last_step ? 3'd0 : step + 3'd1;

    assign req_valid = (state == ISSUE) && needs_bus;
    assign advance   = ((state == ISSUE) && !needs_bus && !ctrl.halt)
                     || ((state == WAIT_BUS) && bus_done);
    assign halted    = (state == HALTED);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= ISSUE;
            step   <= 3'd0;
            opcode <= OP_NOP;
        end else begin
            case (state)
                ISSUE: begin
                    if (ctrl.halt) begin
                        state <= HALTED;
                    end else if (needs_bus) begin
                        state <= WAIT_BUS;
                    end else begin
                        step <= next_step;  // Internal step, one cycle.
                    end
                end
                WAIT_BUS: begin
                    if (bus_done) begin
                        state <= ISSUE;
                        step  <= next_step;
                        if (step == 3'd0) begin
                            opcode <= rdata_byte;
                        end
                    end
                end
                HALTED: ;  // Only reset leaves.
                default: state <= HALTED;
            endcase
        end
    end

    // Halt is sticky and the bus stays quiet.
    assert property (@(posedge clk) disable iff (!rst_n) halted |=> (halted && !req_valid));

    assert property (@(posedge clk) disable iff (!rst_n) step <= 3'd4);

endmodule

//--- hw/acc_datapath.sv
// Core datapath; accumulator, program counter, operand address latch, add/subtract unit and zero test.
`timescale 1ns/10ps

module acc_datapath (
    input  logic                clk,
    input  logic                rst_n,
    input  cpu_pkg::ctrl_word_t ctrl,
    input  logic                advance,
    input  cpu_pkg::byte_t      rdata_byte,
    output cpu_pkg::addr_t      bus_addr,
    output cpu_pkg::byte_t      wdata
);
    import cpu_pkg::*;

    byte_t acc;
    addr_t pc;
    addr_t opnd;       // Absolute address from the instruction stream.

    byte_t alu_b;
    logic  carry_in;
    byte_t alu_y;
    logic  a_zero;
    logic  take_jump;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ALU
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        alu_b    = rdata_byte;
        carry_in = 1'b0;
        if (ctrl.alu_op == ALU_SUB) begin
            alu_b    = ~rdata_byte;  // Two's complement via inverted operand.
            carry_in = 1'b1;
        end
    end

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD,
            ALU_SUB: alu_y = acc + alu_b + {7'd0, carry_in};  // Wraps mod 256.
            default: alu_y = rdata_byte;
        endcase
    end

    assign a_zero    = (acc == 8'h00);
    assign take_jump = ctrl.pc_load && (!ctrl.pc_cond || !a_zero);

    assign bus_addr = (ctrl.addr_sel == SEL_OPND) ? opnd : pc;
    assign wdata    = acc;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Architectural registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc <= 8'h00;
            pc  <= RESET_PC;
        end else if (advance) begin
            if (ctrl.load_a) begin
                acc <= alu_y;
            end
            if (take_jump) begin
                pc <= opnd;
            end else if (ctrl.pc_inc) begin
                pc <= pc + 16'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            if (ctrl.load_opnd_lo) begin
                opnd[7:0] <= rdata_byte;
            end
            if (ctrl.load_opnd_hi) begin
                opnd[15:8] <= rdata_byte;
            end
        end
    end

    // Each step moves pc by at most one source.
    assert property (@(posedge clk) disable iff (!rst_n)
        advance |-> !(ctrl.pc_inc && ctrl.pc_load));

endmodule

//--- hw/axil_master.sv
// AXI4-Lite master; runs one byte read or write per request, placing data on the addressed lane.
`timescale 1ns/10ps

module axil_master (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid,
    input  cpu_pkg::bus_req_t req,
    output logic              bus_done,
    output cpu_pkg::byte_t    rdata_byte,
    output logic              awvalid,
    input  logic              awready,
    output cpu_pkg::axil_aw_t aw,
    output logic              wvalid,
    input  logic              wready,
    output cpu_pkg::axil_w_t  w,
    input  logic              bvalid,
    output logic              bready,
    input  logic [1:0]        bresp,
    output logic              arvalid,
    input  logic              arready,
    output cpu_pkg::axil_ar_t ar,
    input  logic              rvalid,
    output logic              rready,
    input  cpu_pkg::axil_r_t  r
);
    import cpu_pkg::*;

    typedef enum logic [2:0] {M_IDLE, M_WRITE, M_RESP, M_READ, M_DATA} mst_state_e;

    mst_state_e state;
    bus_req_t   req_q;

    assign arvalid = (state == M_READ);
    assign bready  = (state == M_RESP);
    assign rready  = (state == M_DATA);

    assign aw.addr = {req_q.addr[15:2], 2'b00};  // Word aligned.
    assign aw.prot = 3'b000;
    assign ar.addr = {req_q.addr[15:2], 2'b00};
    assign ar.prot = 3'b000;
    assign w.data  = {4{req_q.wdata}};
    assign w.strb  = 4'b0001 << req_q.addr[1:0];

    always_ff @(posedge clk) begin
        if (req_valid && (state == M_IDLE)) begin
            req_q <= req;
        end
        if (rvalid && rready) begin
            rdata_byte <= r.data[{req_q.addr[1:0], 3'b000} +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= M_IDLE;
            awvalid  <= 1'b0;
            wvalid   <= 1'b0;
            bus_done <= 1'b0;
        end else begin
            bus_done <= 1'b0;
            case (state)
                M_IDLE: if (req_valid) begin
                    state   <= req.write ? M_WRITE : M_READ;
                    awvalid <= req.write;
                    wvalid  <= req.write;
                end
                M_WRITE: begin
                    if (awready) awvalid <= 1'b0;
                    if (wready) wvalid <= 1'b0;
                    if ((!awvalid || awready) && (!wvalid || wready)) state <= M_RESP;
                end
                M_RESP: if (bvalid) begin
                    state    <= M_IDLE;
                    bus_done <= 1'b1;
                end
                M_READ: if (arready) state <= M_DATA;
                M_DATA: if (rvalid) begin
                    state    <= M_IDLE;
                    bus_done <= 1'b1;
                end
                default: state <= M_IDLE;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) (awvalid && !awready) |=> awvalid);
    assert property (@(posedge clk) disable iff (!rst_n) (wvalid && !wready) |=> wvalid);
    assert property (@(posedge clk) disable iff (!rst_n) (arvalid && !arready) |=> arvalid);

    // Whole 64 KiB space decodes, so DECERR points at the slave.
    assert property (@(posedge clk) disable iff (!rst_n)
        !((bvalid && bready && (bresp == 2'b11)) || (rvalid && rready && (r.resp == 2'b11))));

endmodule

//--- hw/cpu_top.sv
// Accumulator core top level; wires decoder, sequencer, datapath and the AXI4-Lite master together.
`timescale 1ns/10ps

module cpu_top (
    input  logic              clk,
    input  logic              rst_n,
    output logic              halted,
    output logic              awvalid,
    input  logic              awready,
    output cpu_pkg::axil_aw_t aw,
    output logic              wvalid,
    input  logic              wready,
    output cpu_pkg::axil_w_t  w,
    input  logic              bvalid,
    output logic              bready,
    input  logic [1:0]        bresp,
    output logic              arvalid,
    input  logic              arready,
    output cpu_pkg::axil_ar_t ar,
    input  logic              rvalid,
    output logic              rready,
    input  cpu_pkg::axil_r_t  r
);
    import cpu_pkg::*;

    ctrl_word_t ctrl;
    byte_t      opcode;
    step_t      step;
    logic       req_valid;
    logic       advance;
    logic       bus_done;
    byte_t      rdata_byte;
    addr_t      bus_addr;
    byte_t      wdata;
    bus_req_t   bus_req;

    assign bus_req = '{addr: bus_addr, wdata: wdata, write: ctrl.bus_wr};

    opcode_decoder opcode_decoder_inst (
        .opcode (opcode),
        .step   (step),
        .ctrl   (ctrl)
    );

    step_sequencer step_sequencer_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl),
        .bus_done   (bus_done),
        .rdata_byte (rdata_byte),
        .opcode     (opcode),
        .step       (step),
        .req_valid  (req_valid),
        .advance    (advance),
        .halted     (halted)
    );

    acc_datapath acc_datapath_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl),
        .advance    (advance),
        .rdata_byte (rdata_byte),
        .bus_addr   (bus_addr),
        .wdata      (wdata)
    );

    axil_master axil_master_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req        (bus_req),
        .bus_done   (bus_done),
        .rdata_byte (rdata_byte),
        .awvalid    (awvalid),
        .awready    (awready),
        .aw         (aw),
        .wvalid     (wvalid),
        .wready     (wready),
        .w          (w),
        .bvalid     (bvalid),
        .bready     (bready),
        .bresp      (bresp),
        .arvalid    (arvalid),
        .arready    (arready),
        .ar         (ar),
        .rvalid     (rvalid),
        .rready     (rready),
        .r          (r)
    );

endmodule

//--- verif/cpu_ref_model.svh
// Instruction-level reference model of the accumulator core; included in the testbench module.
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

logic [7:0]  ref_mem [0:65535];  // Working copy of the program image.
logic [15:0] exp_addr [$];       // Expected store trace.
logic [7:0]  exp_data [$];

// Runs the image in ref_mem from address 0 until a halting opcode.
function automatic void run_reference(input int max_instr);
    logic [15:0] pc;
    logic [15:0] ea;
    logic [7:0]  a;
    logic [7:0]  op;
    logic [7:0]  lo;
    logic [7:0]  hi;
    int          n;
    pc = 16'h0000;
    a  = 8'h00;
    for (n = 0; n < max_instr; n++) begin
        op = ref_mem[pc];
        pc = pc + 16'd1;
        if (op >= 8'h08) begin
            return;  // Halt.
        end
        if (op == 8'h01) begin
            a  = ref_mem[pc];
            pc = pc + 16'd1;
        end else if (op != 8'h00) begin
            lo = ref_mem[pc];
            hi = ref_mem[pc + 16'd1];
            pc = pc + 16'd2;
            ea = {hi, lo};  // Little endian operand.
            case (op)
                8'h02: a = ref_mem[ea];
                8'h03: begin
                    ref_mem[ea] = a;
                    exp_addr.push_back(ea);
                    exp_data.push_back(a);
                end
                8'h04: a = a + ref_mem[ea];
                8'h05: a = a - ref_mem[ea];
                8'h06: pc = ea;
                8'h07: begin
                    if (a != 8'h00) begin
                        pc = ea;
                    end
                end
                default: ;
            endcase
        end
    end
endfunction

`endif

//--- verif/tb_cpu_top.sv
// Testbench for cpu_top; AXI4-Lite memory with random stalls, store trace checked against a model.
`timescale 1ns/10ps

module tb_cpu_top;
    import cpu_pkg::*;

    logic clk = 1'b0;
    logic rst_n;
    logic halted;
    logic awvalid, awready, wvalid, wready, bvalid, bready, arvalid, arready, rvalid, rready;
    logic [1:0] bresp;
    axil_aw_t aw;
    axil_w_t  w;
    axil_ar_t ar;
    axil_r_t  r;

    `include "cpu_ref_model.svh"

    logic [7:0]  prog_img [0:65535];
    logic [7:0]  mem [0:65535];
    logic [15:0] act_addr [$];
    logic [7:0]  act_data [$];
    string       test_name;
    int          errors = 0;
    int          asm_pc;

    // Handshakes seen at the last rising edge.
    logic aw_fire, w_fire, b_fire, ar_fire, r_fire;
    logic [15:0] aw_addr_q, ar_addr_q;
    axil_w_t w_q;
    logic aw_have, w_have, b_pend, r_pend;
    int unsigned aw_dly, w_dly, b_dly, ar_dly, r_dly;
    int lane;

    always #10 clk = ~clk;

    cpu_top cpu_top_inst (.*);

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("ERROR %s %s: expected 0x%0h actual 0x%0h", test_name, what, expected, actual);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // AXI4-Lite memory model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        aw_fire <= awvalid && awready;
        w_fire  <= wvalid && wready;
        b_fire  <= bvalid && bready;
        ar_fire <= arvalid && arready;
        r_fire  <= rvalid && rready;
        if (awvalid && awready) aw_addr_q <= aw.addr;
        if (wvalid && wready) w_q <= w;
        if (arvalid && arready) ar_addr_q <= ar.addr;
        if (rst_n && halted && (arvalid || awvalid)) begin
            errors++;
            $display("Bus transaction started after halt in test %s", test_name);
        end
    end

    always @(negedge clk) begin
        if (!rst_n) begin
            {awready, wready, bvalid, arready, rvalid} = '0;
            {aw_have, w_have, b_pend, r_pend} = '0;
            {aw_dly, w_dly, b_dly, ar_dly, r_dly} = '0;
        end else begin
            if (aw_fire) begin
                awready = 1'b0;
                aw_have = 1'b1;
                aw_dly  = $urandom % 4;
            end else if (awvalid && !awready && !aw_have) begin
                if (aw_dly == 0) awready = 1'b1;
                else aw_dly--;
            end
            if (w_fire) begin
                wready = 1'b0;
                w_have = 1'b1;
                w_dly  = $urandom % 4;
            end else if (wvalid && !wready && !w_have) begin
                if (w_dly == 0) wready = 1'b1;
                else w_dly--;
            end
            if (aw_have && w_have) begin
                check_value("strobe one-hot", 1, $countones(w_q.strb));
                check_value("aw aligned", 0, aw_addr_q[1:0]);
                lane = $clog2(w_q.strb);
                mem[{aw_addr_q[15:2], 2'(lane)}] = w_q.data[lane*8 +: 8];
                act_addr.push_back({aw_addr_q[15:2], 2'(lane)});
                act_data.push_back(w_q.data[lane*8 +: 8]);
                {aw_have, w_have} = 2'b00;
                b_pend = 1'b1;
                b_dly  = $urandom % 4;
            end
            if (b_fire) begin
                bvalid = 1'b0;
            end else if (b_pend && !bvalid) begin
                if (b_dly == 0) {bvalid, b_pend} = 2'b10;
                else b_dly--;
            end
            if (ar_fire) begin
                arready = 1'b0;
                r_pend  = 1'b1;
                r_dly   = $urandom % 4;
                ar_dly  = $urandom % 4;
            end else if (arvalid && !arready) begin
                if (ar_dly == 0) arready = 1'b1;
                else ar_dly--;
            end
            if (r_fire) begin
                rvalid = 1'b0;
            end else if (r_pend && !rvalid) begin
                if (r_dly == 0) begin
                    r.data = {mem[{ar_addr_q[15:2], 2'd3}], mem[{ar_addr_q[15:2], 2'd2}],
                              mem[{ar_addr_q[15:2], 2'd1}], mem[{ar_addr_q[15:2], 2'd0}]};
                    r.resp = 2'b00;
                    {rvalid, r_pend} = 2'b10;
                end else begin
                    r_dly--;
                end
            end
        end
    end

    // Compare each accepted store with the reference trace.
    always @(posedge clk) begin
        if (act_addr.size() > 0) begin
            if (exp_addr.size() == 0) begin
                errors++;
                $display("Store to 0x%0h not predicted in test %s", act_addr[0], test_name);
            end else begin
                check_value("store address", exp_addr.pop_front(), act_addr[0]);
                check_value("store data", exp_data.pop_front(), act_data[0]);
            end
            void'(act_addr.pop_front());
            void'(act_data.pop_front());
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Program building
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic clear_image();
        for (int a = 0; a < 65536; a++) begin
            prog_img[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h5a;
        end
        asm_pc = 0;
    endtask

    task automatic emit(input logic [7:0] b);
        prog_img[asm_pc] = b;
        asm_pc++;
    endtask

    task automatic emit_abs(input logic [7:0] op, input logic [15:0] ea);
        emit(op);
        emit(ea[7:0]);
        emit(ea[15:8]);
    endtask

    function automatic logic [7:0] halt_opcode();
        return 8'h08 + 8'($urandom % 248);
    endfunction

    // Reset, load the image, predict the trace and run until halt or abort.
    task automatic run_program(input string name, input int abort_cycles);
        int cyc;
        @(negedge clk);
        rst_n = 1'b0;
        repeat (2) @(negedge clk);
        test_name = name;
        act_addr.delete();
        act_data.delete();
        exp_addr.delete();
        exp_data.delete();
        for (int a = 0; a < 65536; a++) begin
            mem[a]     = prog_img[a];
            ref_mem[a] = prog_img[a];
        end
        run_reference(4000);
        rst_n = 1'b1;
        for (cyc = 0; cyc < 20000 && !halted; cyc++) begin
            if (abort_cycles > 0 && cyc == abort_cycles) break;
            @(negedge clk);
        end
        if (abort_cycles > 0 && !halted) begin
            $display("Test %s interrupted by reset after %0d cycles", name, cyc);
        end else if (!halted) begin
            errors++;
            $display("Timeout waiting for halted in test %s", name);
        end else begin
            repeat (8) @(negedge clk);  // Bus must stay idle.
            check_value("stores missing", 0, exp_addr.size());
        end
    endtask

    initial begin
        void'($urandom(32'h9f62));
        rst_n = 1'b0;
        {awready, wready, bvalid, arready, rvalid} = '0;
        bresp = 2'b00;
        r = '0;

        clear_image();  // LDI and STA on every lane.
        for (int i = 0; i < 4; i++) begin
            emit(OP_LDI);
            emit(8'($urandom));
            emit_abs(OP_STA, 16'h8000 + 16'(i));
        end
        emit(halt_opcode());
        run_program("lanes", 0);

        clear_image();  // LDA, ADD, SUB.
        for (int i = 0; i < 6; i++) begin
            for (int k = 0; k < 3; k++) prog_img[16'h9000 + 16'(3*i + k)] = 8'($urandom);
            emit_abs(OP_LDA, 16'h9000 + 16'(3*i));
            emit_abs(OP_ADD, 16'h9001 + 16'(3*i));
            emit_abs(OP_STA, 16'h8100 + 16'(2*i));
            emit_abs(OP_SUB, 16'h9002 + 16'(3*i));
            emit_abs(OP_STA, 16'h8101 + 16'(2*i));
            emit(OP_NOP);
        end
        emit(halt_opcode());
        run_program("arith", 0);
        run_program("arith_reset", 150);
        run_program("arith_rerun", 0);

        clear_image();  // JMP skip and JNZ countdown.
        prog_img[16'h9100] = 8'h01;
        emit(OP_LDI);
        emit(8'h11);
        emit_abs(OP_JMP, 16'h0008);
        emit_abs(OP_STA, 16'h8200);  // Skipped.
        emit_abs(OP_STA, 16'h8201);
        emit(OP_LDI);
        emit(8'd3 + 8'($urandom % 8));
        emit_abs(OP_STA, 16'h8300);  // Loop top at 0x000d.
        emit_abs(OP_SUB, 16'h9100);
        emit_abs(OP_JNZ, 16'h000d);
        emit_abs(OP_STA, 16'h8301);
        emit(halt_opcode());
        run_program("jumps", 0);

        clear_image();  // Halt as the very first opcode.
        emit(halt_opcode());
        emit_abs(OP_STA, 16'h8400);
        run_program("halt", 0);

        $display("Checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+verif
hw/cpu_pkg.sv
hw/opcode_decoder.sv
hw/step_sequencer.sv
hw/acc_datapath.sv
hw/axil_master.sv
hw/cpu_top.sv
verif/tb_cpu_top.sv

//--- run.sh
#!/usr/bin/env bash
# Compile the core and its testbench with Verilator, run it and check the log.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f build.f \
    --top-module tb_cpu_top \
    -Mdir obj_dir -o sim_cpu

./obj_dir/sim_cpu > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST PASSED$" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
